// ==== project.f ====
+incdir+src
+incdir+testbench
src/calib_pkg.sv
src/calib_code_gen.sv
src/calib_override_ctrl.sv
src/calib_phase_checker.sv
src/calib_master_top.sv
testbench/tb_calib_master.sv

// ==== src/calib_code_gen.sv ====
// calibration code generator: maps phase and blessed flag to the padded override word
`timescale 1ns/1ps
`include "calib_consts.svh"

module calib_code_gen
(
   input  calib_pkg::calib_phase_e phase_i,
   input  logic                    blessed_i,
   output logic [`CALIB_WIDTH:0]   code_o
);

   import calib_pkg::*;

   // width of the five-bit code and of the pad filling the rest of the word
   localparam int code_w_lp = 5;
   localparam int pad_w_lp  = `CALIB_WIDTH + 1 - code_w_lp;

   // alternating 0101.. pad, keeps the idle pads toggling evenly
   localparam logic [pad_w_lp-1:0] pad_pattern_lp = pad_w_lp'({pad_w_lp{2'b01}});

   logic [code_w_lp-1:0] code;
   logic                 activating;

   // code table picked with stuck-at faults in mind
   always_comb
   begin
      activating = 1'b0;
      case (phase_i)
         PHASE_CLK_RESET:
            code = 5'b0_111_1;
         // noisy phases, kept far from the active pattern
         PHASE_1:
            code = 5'b0_010_0;
         PHASE_2:
            code = 5'b0_010_1;
         PHASE_3:
            code = 5'b0_001_0;
         PHASE_4:
            code = 5'b0_001_1;
         PHASE_DONE:
         begin
            // blessed channel gets the activation code
            // otherwise a pattern far away from it, so a stuck pad
            // cannot activate the channel by accident
            if (blessed_i)
               code = 5'b0_011_0;
            else
               code = 5'b0_100_1;
            activating = blessed_i;
         end
         // inactive phases
         default:
            code = 5'b0_000_1;
      endcase
   end

   // pad bits inverted only while activating
   assign code_o = {code, pad_pattern_lp ^ {pad_w_lp{activating}}};

endmodule

// ==== src/calib_consts.svh ====
// calibration master constants: channel width, test count, window sizes and bypass mask
`ifndef CALIB_CONSTS_SVH
`define CALIB_CONSTS_SVH

// channel data width, valid bit not included
// override and snoop words are CALIB_WIDTH+1 bits wide
`define CALIB_WIDTH 8

// number of real tests
// pass and good vectors carry one extra bit for the final activation phase
`define CALIB_TESTS 5

// prepare window counter width
`define CALIB_CTR_BITS 10

// log2 of the token-reset window
// counter values 16..31 send the token pattern
`define CALIB_LG_TOKEN 4

// log2 of the hold time after prepare falls
`define CALIB_LG_HOLD 5

// consecutive-match counter width, lock at saturation
`define CALIB_MATCH_BITS 6

// phases forced to pass, no real checker behind them
`define CALIB_BYPASS 5'b11010

`endif

// ==== src/calib_master_top.sv ====
// calibration master top: code generator, override controller and receive checker
`timescale 1ns/1ps
`include "calib_consts.svh"

module calib_master_top
(
   input  logic                      in_clk_i,
   input  logic                      rst_i,
   input  calib_pkg::calib_phase_e   phase_i,
   input  logic                      prepare_i,
   input  logic                      blessed_i,
   input  logic [`CALIB_WIDTH:0]     snoop_neg_i,
   input  logic [`CALIB_WIDTH:0]     snoop_pos_i,
   output logic                      override_en_o,
   output logic [`CALIB_WIDTH:0]     override_data_o,
   output logic [`CALIB_TESTS:0]     test_pass_o,
   output logic                      infinite_credits_o
);

   // padded code for the current phase
   logic [`CALIB_WIDTH:0] code;
   // checker verdict per phase
   logic [`CALIB_TESTS:0] phase_good;

   calib_code_gen i_code_gen
   (
      .phase_i   (phase_i),
      .blessed_i (blessed_i),
      .code_o    (code)
   );

   calib_override_ctrl i_override_ctrl
   (
      .in_clk_i        (in_clk_i),
      .rst_i           (rst_i),
      .phase_i         (phase_i),
      .prepare_i       (prepare_i),
      .code_i          (code),
      .phase_good_i    (phase_good),
      .override_en_o   (override_en_o),
      .override_data_o (override_data_o),
      .test_pass_o     (test_pass_o)
   );

   calib_phase_checker i_phase_checker
   (
      .in_clk_i           (in_clk_i),
      .rst_i              (rst_i),
      .phase_i            (phase_i),
      .prepare_i          (prepare_i),
      .snoop_neg_i        (snoop_neg_i),
      .snoop_pos_i        (snoop_pos_i),
      .phase_good_o       (phase_good),
      .infinite_credits_o (infinite_credits_o)
   );

endmodule

// ==== src/calib_override_ctrl.sv ====
// calibration override controller: prepare/finish sequencing, token-reset insertion and pass bits
`timescale 1ns/1ps
`include "calib_consts.svh"

module calib_override_ctrl
(
   input  logic                      in_clk_i,
   input  logic                      rst_i,
   input  calib_pkg::calib_phase_e   phase_i,
   input  logic                      prepare_i,
   input  logic [`CALIB_WIDTH:0]     code_i,
   input  logic [`CALIB_TESTS:0]     phase_good_i,
   output logic                      override_en_o,
   output logic [`CALIB_WIDTH:0]     override_data_o,
   output logic [`CALIB_TESTS:0]     test_pass_o
);

   import calib_pkg::*;

   calib_ctrl_state_e           state_r;
   calib_ctrl_state_e           state_n;
   logic [`CALIB_CTR_BITS-1:0]  ctr_r;
   logic [`CALIB_CTR_BITS-1:0]  ctr_n;
   logic [`CALIB_CTR_BITS-1:0]  ctr_p1;
   logic                        prepare_r;
   logic                        prepare_edge;
   logic                        token_window;
   logic                        phase_valid;
   logic                        en_r;
   logic                        en_n;
   logic [`CALIB_WIDTH:0]       data_r;
   logic [`CALIB_WIDTH:0]       data_n;
   logic [`CALIB_WIDTH:0]       token_pattern;
   logic [`CALIB_TESTS:0]       pass_r;
   logic [`CALIB_TESTS:0]       pass_n;

   // counter restarts on both prepare edges
   assign prepare_edge = prepare_i ^ prepare_r;
   assign ctr_p1       = ctr_r + 1'b1;

   // second 2^lg_token block of the window asks the slave to send its token
   assign token_window = (ctr_r[`CALIB_CTR_BITS-1:`CALIB_LG_TOKEN] == 1);

   // 11, zeros, low two phase bits
   assign token_pattern = {2'b11, {(`CALIB_WIDTH-3){1'b0}}, phase_i[1:0]};

   // phases 6 and 7 have no pass bit
   assign phase_valid = (phase_i <= PHASE_DONE);

   always_comb
   begin
      state_n = state_r;
      ctr_n   = ctr_r;
      pass_n  = pass_r;
      en_n    = 1'b0;
      data_n  = '0;

      if (prepare_i)
      begin
         // slave in reset, drive the phase code
         state_n = CTRL_PREPARE;
         en_n    = 1'b1;
         ctr_n   = ctr_p1;
         if (phase_valid)
            pass_n[phase_i] = 1'b0;
         if (token_window)
            data_n = token_pattern;
         else
            data_n = code_i;
      end
      else if (state_r != CTRL_IDLE)
      begin
         // keep the code up a while after prepare drops
         state_n = CTRL_FINISH;
         en_n    = 1'b1;
         ctr_n   = ctr_p1;
         data_n  = code_i;
         // wait for the counter restart before trusting the hold bit
         if (ctr_r[`CALIB_LG_HOLD] && !prepare_r)
            state_n = CTRL_IDLE;
      end
      else
      begin
         // idle, pass bit follows the checker verdict
         if (phase_valid)
            pass_n[phase_i] = phase_good_i[phase_i];
      end
   end

   always_ff @(posedge in_clk_i)
   begin
      if (rst_i)
      begin
         state_r   <= CTRL_IDLE;
         ctr_r     <= '0;
         prepare_r <= 1'b0;
         pass_r    <= '0;
         en_r      <= 1'b0;
         data_r    <= '0;
      end
      else
      begin
         state_r   <= state_n;
         prepare_r <= prepare_i;
         pass_r    <= pass_n;
         en_r      <= en_n;
         data_r    <= data_n;
         if (prepare_edge)
            ctr_r <= '0;
         else
            ctr_r <= ctr_n;
      end
   end

   assign override_en_o   = en_r;
   assign override_data_o = data_r;
   assign test_pass_o     = pass_r;

endmodule

// ==== src/calib_phase_checker.sv ====
// calibration phase checker: snoops the receive channel for a counter stream and reports per-phase good
`timescale 1ns/1ps
`include "calib_consts.svh"

module calib_phase_checker
(
   input  logic                      in_clk_i,
   input  logic                      rst_i,
   input  calib_pkg::calib_phase_e   phase_i,
   input  logic                      prepare_i,
   input  logic [`CALIB_WIDTH:0]     snoop_neg_i,
   input  logic [`CALIB_WIDTH:0]     snoop_pos_i,
   output logic [`CALIB_TESTS:0]     phase_good_o,
   output logic                      infinite_credits_o
);

   import calib_pkg::*;

   localparam int word_w_lp = `CALIB_WIDTH + 1;
   localparam int pair_w_lp = 2 * word_w_lp;

   localparam logic [`CALIB_TESTS-1:0] bypass_lp = `CALIB_BYPASS;

   logic [`CALIB_TESTS-1:0]      test_en;
   logic [word_w_lp-1:0]         last_pos_r;
   logic [word_w_lp-1:0]         last_neg_r;
   logic [word_w_lp-1:0]         last_last_pos_r;
   logic [pair_w_lp-1:0]         pos_neg_next;
   logic [pair_w_lp-1:0]         neg_pos_next;
   logic                         pos_neg_match;
   logic                         neg_pos_match;
   logic [`CALIB_MATCH_BITS-1:0] pos_neg_cnt_r;
   logic [`CALIB_MATCH_BITS-1:0] neg_pos_cnt_r;
   logic                         phase2_lock;

   // one enable per test, only outside the prepare window
   assign test_en = `CALIB_TESTS'(1 << phase_i) & {`CALIB_TESTS{~prepare_i}};

   // neg carries the low half
   // previous {pos, neg} plus one must equal the current pair
   assign pos_neg_next  = {last_pos_r, last_neg_r} + 1'b1;
   assign pos_neg_match = (pos_neg_next == {snoop_pos_i, snoop_neg_i});

   // neg carries the high half, pos lags by one edge
   // so pair neg with the pos sampled a cycle later
   assign neg_pos_next  = {last_neg_r, last_last_pos_r} + 1'b1;
   assign neg_pos_match = (neg_pos_next == {snoop_neg_i, last_pos_r});

   // snoop history, only tracked during test 2
   always_ff @(posedge in_clk_i)
   begin
      if (test_en[PHASE_2])
      begin
         last_pos_r      <= snoop_pos_i;
         last_neg_r      <= snoop_neg_i;
         last_last_pos_r <= last_pos_r;
      end
   end

   // saturating run-length counters, cleared by any miss
   always_ff @(posedge in_clk_i)
   begin
      if (rst_i)
      begin
         pos_neg_cnt_r <= '0;
         neg_pos_cnt_r <= '0;
      end
      else if (test_en[PHASE_2])
      begin
         if (pos_neg_match)
         begin
            if (!(&pos_neg_cnt_r))
               pos_neg_cnt_r <= pos_neg_cnt_r + 1'b1;
         end
         else
            pos_neg_cnt_r <= '0;

         if (neg_pos_match)
         begin
            if (!(&neg_pos_cnt_r))
               neg_pos_cnt_r <= neg_pos_cnt_r + 1'b1;
         end
         else
            neg_pos_cnt_r <= '0;
      end
   end

   // either half-ordering may lock
   assign phase2_lock = (&pos_neg_cnt_r) | (&neg_pos_cnt_r);

   // clock reset phase always passes
   assign phase_good_o[PHASE_CLK_RESET] = 1'b1;
   // phases 1, 3 and 4 report the bypass mask only
   assign phase_good_o[PHASE_1]         = bypass_lp[PHASE_1];
   assign phase_good_o[PHASE_2]         = phase2_lock | bypass_lp[PHASE_2];
   assign phase_good_o[PHASE_3]         = bypass_lp[PHASE_3];
   assign phase_good_o[PHASE_4]         = bypass_lp[PHASE_4];
   // activation phase always passes
   assign phase_good_o[PHASE_DONE]      = 1'b1;

   // loopback phases, output module ignores credits
   assign infinite_credits_o = test_en[PHASE_3] | test_en[PHASE_4];

endmodule

// ==== src/calib_pkg.sv ====
// calibration master types: phase numbers and prepare sequencer states
package calib_pkg;

   // calibration phase number driven by the channel controller
   // phase 0 resets the slave clock
   // phase 5 activates or deactivates the channel
   typedef enum logic [2:0]
   {
      PHASE_CLK_RESET = 3'd0,
      PHASE_1         = 3'd1,
      PHASE_2         = 3'd2,
      PHASE_3         = 3'd3,
      PHASE_4         = 3'd4,
      PHASE_DONE      = 3'd5,
      // no calibration activity in these two
      PHASE_INACT_6   = 3'd6,
      PHASE_INACT_7   = 3'd7
   } calib_phase_e;

   // override sequencer
   // idle: no override, pass bits follow the checker
   // prepare: slave held in reset, code and token pattern sent
   // finish: code held for a while after prepare drops
   typedef enum logic [1:0]
   {
      CTRL_IDLE    = 2'd0,
      CTRL_PREPARE = 2'd1,
      CTRL_FINISH  = 2'd2
   } calib_ctrl_state_e;

endpackage

// ==== testbench/tb_calib_model.svh ====
// calibration master reference model: expected override codes, token pattern and pass bits
`ifndef TB_CALIB_MODEL_SVH
`define TB_CALIB_MODEL_SVH

// five-bit phase code followed by the 0101 pad
// pad is flipped only for the blessed final phase
function automatic logic [`CALIB_WIDTH:0] expected_code(input logic [2:0] phase,
                                                        input logic blessed);
   logic [4:0] code;
   logic [3:0] pad;
   pad = 4'b0101;
   case (phase)
      3'd0:    code = 5'b0_111_1;
      3'd1:    code = 5'b0_010_0;
      3'd2:    code = 5'b0_010_1;
      3'd3:    code = 5'b0_001_0;
      3'd4:    code = 5'b0_001_1;
      3'd5:    code = blessed ? 5'b0_011_0 : 5'b0_100_1;
      default: code = 5'b0_000_1;
   endcase
   if ((phase == 3'd5) && blessed)
      pad = ~pad;
   return {code, pad};
endfunction

// token reset request: 11, zeros, low phase bits
function automatic logic [`CALIB_WIDTH:0] token_word(input logic [2:0] phase);
   return {2'b11, {(`CALIB_WIDTH-3){1'b0}}, phase[1:0]};
endfunction

// second block of 2^lg_token counts in the prepare window
function automatic logic in_token_window(input int win);
   return (win >= (1 << `CALIB_LG_TOKEN)) && (win < (2 << `CALIB_LG_TOKEN));
endfunction

// verdict per phase, 0 and 5 always pass, 2 needs lock unless bypassed
function automatic logic expected_pass_bit(input logic [2:0] phase, input logic locked);
   logic [`CALIB_TESTS-1:0] bypass;
   bypass = `CALIB_BYPASS;
   if ((phase == 3'd0) || (phase == 3'd5))
      return 1'b1;
   else if (phase == 3'd2)
      return locked | bypass[2];
   else
      return bypass[phase];
endfunction

`endif

// ==== testbench/tb_calib_master.sv ====
// calibration master testbench: seeded random phase runs checked against a reference model
`timescale 1ns/1ps
`include "calib_consts.svh"

module tb_calib_master;

   import calib_pkg::*;

   `include "tb_calib_model.svh"

   localparam int clk_period_lp = 4;
   // longest run: setup, 81 prepare, 40 finish and 70 idle cycles
   localparam int run_cycles_lp = 4 + 81 + 40 + 70;
   localparam int num_runs_lp   = 8;
   localparam int timeout_ns_lp = (8 + num_runs_lp * run_cycles_lp + 200) * clk_period_lp;

   logic                  in_clk;
   logic                  rst;
   calib_phase_e          phase;
   logic                  prepare;
   logic                  blessed;
   logic [`CALIB_WIDTH:0] snoop_neg;
   logic [`CALIB_WIDTH:0] snoop_pos;
   logic                  override_en;
   logic [`CALIB_WIDTH:0] override_data;
   logic [`CALIB_TESTS:0] test_pass;
   logic                  infinite_credits;

   integer                seed = 73633;
   int                    checks = 0;
   int                    value_errors = 0;
   int                    order_errors = 0;
   // snoop source, counter stream or random words
   logic                  snoop_count;
   logic [17:0]           snoop_cnt;
   // pass vector as the model expects it
   logic [`CALIB_TESTS:0] pass_model;
   // blessed flag of the first final-phase visit, the second visit takes the other value
   logic                  blessed_pick;

   calib_master_top i_dut
   (
      .in_clk_i           (in_clk),
      .rst_i              (rst),
      .phase_i            (phase),
      .prepare_i          (prepare),
      .blessed_i          (blessed),
      .snoop_neg_i        (snoop_neg),
      .snoop_pos_i        (snoop_pos),
      .override_en_o      (override_en),
      .override_data_o    (override_data),
      .test_pass_o        (test_pass),
      .infinite_credits_o (infinite_credits)
   );

   initial
   begin
      in_clk = 1'b0;
      forever #(clk_period_lp / 2) in_clk = ~in_clk;
   end

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      if (act !== exp)
      begin
         $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
         value_errors++;
      end
   endtask

   // one rising edge, snoop words refreshed on it
   task automatic tick();
      @(posedge in_clk);
      if (snoop_count)
      begin
         {snoop_pos, snoop_neg} <= snoop_cnt;
         snoop_cnt              <= snoop_cnt + 1'b1;
      end
      else
      begin
         snoop_pos <= 9'($random(seed));
         snoop_neg <= 9'($random(seed));
      end
   endtask

   // select phase, prepare for a random length, finish, then idle
   task automatic run_phase(input logic [2:0] p, input logic lock_exp, input logic b);
      int                    r;
      int                    len;
      int                    j;
      int                    drop;
      logic [`CALIB_WIDTH:0] code;
      r    = $random(seed);
      len  = 40 + ((r & 32'h7fff_ffff) % 41);
      code = expected_code(p, b);
      tick();
      phase   <= calib_phase_e'(p);
      blessed <= b;
      tick();
      tick();
      prepare <= 1'b1;
      // window count starts when the DUT samples prepare high
      // output is registered one edge after that
      for (j = 1; j <= len + 1; j++)
      begin
         tick();
         if (j == len + 1)
            prepare <= 1'b0;
         @(negedge in_clk);
         check_value("override_en_o", 1'b1, override_en);
         if (in_token_window(j - 2))
            check_value("override_data_o", token_word(p), override_data);
         else
            check_value("override_data_o", code, override_data);
      end
      // this phase's bit cleared, the others untouched
      check_value("test_pass_o", pass_model & ~(7'b1 << p), test_pass);
      // code held after prepare falls until the hold bit
      drop = 0;
      j    = 0;
      while ((drop == 0) && (j < 40))
      begin
         tick();
         @(negedge in_clk);
         j++;
         if (override_en)
            check_value("override_data_o", code, override_data);
         else
            drop = j;
      end
      if ((drop < 32) || (drop > 36))
      begin
         if (drop == 0)
            $display("override_en_o still high 40 cycles after prepare fell, phase %0d", p);
         else
            $display("override_en_o dropped %0d cycles after prepare fell, phase %0d", drop, p);
         order_errors++;
      end
      repeat (70) tick();
      @(negedge in_clk);
      pass_model[p] = expected_pass_bit(p, lock_exp);
      check_value("test_pass_o", pass_model, test_pass);
   endtask

   // credits ignored only in the loopback phases outside prepare
   always @(negedge in_clk)
   begin
      if (!rst)
         check_value("infinite_credits_o",
                     ((phase == PHASE_3) || (phase == PHASE_4)) && !prepare,
                     infinite_credits);
   end

   initial
   begin
      rst          = 1'b1;
      phase        = PHASE_CLK_RESET;
      prepare      = 1'b0;
      blessed      = 1'b0;
      snoop_pos    = '0;
      snoop_neg    = '0;
      snoop_count  = 1'b0;
      snoop_cnt    = '0;
      pass_model   = '0;
      blessed_pick = 1'b0;
      repeat (8) tick();
      rst <= 1'b0;
      @(negedge in_clk);
      check_value("override_en_o", 1'b0, override_en);
      check_value("override_data_o", 0, override_data);
      check_value("test_pass_o", 0, test_pass);
      check_value("infinite_credits_o", 1'b0, infinite_credits);
      run_phase(3'd0, 1'b0, 1'b0);
      run_phase(3'd1, 1'b0, 1'b0);
      // incrementing stream from a random start, phase 2 must lock
      snoop_count = 1'b1;
      snoop_cnt   = 18'($random(seed));
      run_phase(3'd2, 1'b1, 1'b0);
      snoop_count = 1'b0;
      run_phase(3'd3, 1'b0, 1'b0);
      run_phase(3'd4, 1'b0, 1'b0);
      // both blessed values visited, starting from a random one
      blessed_pick = 1'($random(seed));
      run_phase(3'd5, 1'b0, blessed_pick);
      run_phase(3'd5, 1'b0, ~blessed_pick);
      // random snoop words, no lock
      run_phase(3'd2, 1'b0, 1'b0);
      $display("checks %0d, value errors %0d, ordering errors %0d",
               checks, value_errors, order_errors);
      if ((value_errors + order_errors) == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

   initial
   begin
      #(timeout_ns_lp);
      $display("watchdog expired after %0d ns, run did not complete", timeout_ns_lp);
      $display("Test failed");
      $finish;
   end

endmodule
